/* design/cache_pkg.sv */
package cache_pkg;

    // stored data is one byte wide
    localparam int DATA_WIDTH = 8;

    // backing RAM geometry
    localparam int RAM_DEPTH = 256;
    localparam int ADDR_WIDTH = $clog2(RAM_DEPTH);

    // default cache geometry, 4 ways x 4 sets = 16 lines
    localparam int DEF_WAYS = 4;
    localparam int DEF_SETS = 4;

    // acceptance edge to done, in cycles
    localparam int HIT_LATENCY = 2;
    localparam int MISS_LATENCY = 3;

    // one bit selects the access kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // request as presented with req_valid
    typedef struct packed {
        cache_op_e               op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
    } cache_req_t;

    // completion data
    // read data on a read, zero on a write
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } cache_rsp_t;

endpackage

/* design/ram_store.sv */
`timescale 1ns/1ps

module ram_store (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              en,
    input  logic                              we,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]  addr,
    input  logic [cache_pkg::DATA_WIDTH-1:0]  wdata,
    output logic [cache_pkg::DATA_WIDTH-1:0]  rdata
);

    // word storage, every entry starts at zero
    logic [cache_pkg::DATA_WIDTH-1:0] mem [cache_pkg::RAM_DEPTH];

    // write port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cache_pkg::RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // read port
    // data shows up the cycle after en is sampled
    // a write leaves rdata untouched
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (en && !we) begin
            rdata <= mem[addr];
        end
    end

    // the controller only raises en while a request is held,
    // so the address must never float during an access
    assert property (@(posedge clk) disable iff (rst)
        en |-> !$isunknown(addr))
        else $error("ram_store: access with unknown address");

endmodule

/* design/cache_way_store.sv */
`timescale 1ns/1ps

module cache_way_store #(
    parameter int ways = cache_pkg::DEF_WAYS,
    parameter int sets = cache_pkg::DEF_SETS
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [$clog2(sets)-1:0]                           lookup_index,
    input  logic [cache_pkg::ADDR_WIDTH-$clog2(sets)-1:0]     lookup_tag,
    output logic                                              hit,
    output logic [$clog2(ways)-1:0]                           hit_way,
    output logic [cache_pkg::DATA_WIDTH-1:0]                  hit_data,
    output logic [ways-1:0]                                   valid_mask,
    input  logic                                              line_we,
    input  logic [$clog2(ways)-1:0]                           line_way,
    input  logic [cache_pkg::DATA_WIDTH-1:0]                  line_data
);

    localparam int way_w = $clog2(ways);
    localparam int tag_w = cache_pkg::ADDR_WIDTH - $clog2(sets);

    // line state, indexed [set][way]
    logic [tag_w-1:0]                tag_q  [sets][ways];
    logic [cache_pkg::DATA_WIDTH-1:0] data_q [sets][ways];
    logic [ways-1:0]                 valid_q [sets];

    // one-hot match across the ways of the addressed set
    logic [ways-1:0] hit_vec;

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            hit_vec[w] = valid_q[lookup_index][w] && (tag_q[lookup_index][w] == lookup_tag);
        end
    end

    // encode the matching way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit_vec[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    assign hit        = |hit_vec;
    assign hit_data   = data_q[lookup_index][hit_way];
    assign valid_mask = valid_q[lookup_index];

    // valid bits are the only control state here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (line_we) begin
            valid_q[lookup_index][line_way] <= 1'b1;
        end
    end

    // tag and data follow the same write strobe
    // the update reuses the index and tag of the current lookup
    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_q[lookup_index][line_way]  <= lookup_tag;
            data_q[lookup_index][line_way] <= line_data;
        end
    end

    // allocation picks the victim only on a miss, so a tag never lands twice in a set
    assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("cache_way_store: more than one way hit, vec %h", hit_vec);

endmodule

/* design/cache_lru.sv */
`timescale 1ns/1ps

module cache_lru #(
    parameter int ways = cache_pkg::DEF_WAYS,
    parameter int sets = cache_pkg::DEF_SETS
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [$clog2(sets)-1:0]   lookup_index,
    input  logic [ways-1:0]           valid_mask,
    output logic [$clog2(ways)-1:0]   victim_way,
    input  logic                      touch,
    input  logic [$clog2(ways)-1:0]   touch_way
);

    localparam int way_w = $clog2(ways);

    // age rank per way, 0 is youngest and ways-1 is oldest
    logic [way_w-1:0] rank_q [sets][ways];

    // set of ranks held per set, all ones means a proper permutation
    logic [sets-1:0] perm_ok;

    // touched way becomes youngest
    // only the ways younger than it move one step older
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    rank_q[s][w] <= way_w'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < ways; w++) begin
                if (way_w'(w) == touch_way) begin
                    rank_q[lookup_index][w] <= '0;
                end else if (rank_q[lookup_index][w] < rank_q[lookup_index][touch_way]) begin
                    rank_q[lookup_index][w] <= rank_q[lookup_index][w] + 1'b1;
                end
            end
        end
    end

    // victim choice
    // oldest way first, then the lowest invalid way overrides it
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (rank_q[lookup_index][w] == way_w'(ways - 1)) begin
                victim_way = way_w'(w);
            end
        end
        for (int w = ways - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = way_w'(w);
            end
        end
    end

    always_comb begin
        logic [ways-1:0] seen;
        for (int s = 0; s < sets; s++) begin
            seen = '0;
            for (int w = 0; w < ways; w++) begin
                seen[rank_q[s][w]] = 1'b1;
            end
            perm_ok[s] = &seen;
        end
    end

    assert property (@(posedge clk) disable iff (rst) &perm_ok)
        else $error("cache_lru: ranks no longer a permutation, ok %b", perm_ok);

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int ways = cache_pkg::DEF_WAYS,
    parameter int sets = cache_pkg::DEF_SETS
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          req_valid,
    input  cache_pkg::cache_req_t                         req,
    output logic                                          req_ready,
    output logic                                          done,
    output cache_pkg::cache_rsp_t                         rsp,
    output logic [$clog2(sets)-1:0]                       lookup_index,
    output logic [cache_pkg::ADDR_WIDTH-$clog2(sets)-1:0] lookup_tag,
    input  logic                                          hit,
    input  logic [$clog2(ways)-1:0]                       hit_way,
    input  logic [cache_pkg::DATA_WIDTH-1:0]              hit_data,
    output logic                                          line_we,
    output logic [$clog2(ways)-1:0]                       line_way,
    output logic [cache_pkg::DATA_WIDTH-1:0]              line_data,
    input  logic [$clog2(ways)-1:0]                       victim_way,
    output logic                                          touch,
    output logic [$clog2(ways)-1:0]                       touch_way,
    output logic                                          ram_en,
    output logic                                          ram_we,
    output logic [cache_pkg::ADDR_WIDTH-1:0]              ram_addr,
    output logic [cache_pkg::DATA_WIDTH-1:0]              ram_wdata,
    input  logic [cache_pkg::DATA_WIDTH-1:0]              ram_rdata
);

    localparam int idx_w = $clog2(sets);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_MEM,
        S_DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    // held request, payload only
    cache_pkg::cache_req_t req_q;
    logic                  is_write;
    logic                  accept;
    logic [$clog2(ways)-1:0] way_sel;
    cache_pkg::cache_rsp_t rsp_sel;
    cache_pkg::cache_rsp_t rsp_q;

    assign accept   = req_valid && req_ready;
    assign is_write = (req_q.op == cache_pkg::OP_WRITE);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // hit goes straight to done, a miss spends one cycle on the RAM
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (accept) state_d = S_LOOKUP;
            S_LOOKUP: state_d = hit ? S_DONE : S_MEM;
            S_MEM:    state_d = S_DONE;
            S_DONE:   state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_ready = (state_q == S_IDLE);
    assign done      = (state_q == S_DONE);

    // lookup address split
    assign lookup_index = req_q.addr[idx_w-1:0];
    assign lookup_tag   = req_q.addr[cache_pkg::ADDR_WIDTH-1:idx_w];

    // write-through
    // a write hit goes out during lookup, every miss during the memory cycle
    assign ram_en    = (state_q == S_MEM) || ((state_q == S_LOOKUP) && is_write && hit);
    assign ram_we    = is_write;
    assign ram_addr  = req_q.addr;
    assign ram_wdata = req_q.wdata;

    // store and LRU stay untouched until the done edge, so hit and victim still hold
    assign way_sel = hit ? hit_way : victim_way;

    // read miss fills from RAM data, any write updates or allocates
    assign line_we   = done && (is_write || !hit);
    assign line_way  = way_sel;
    assign line_data = is_write ? req_q.wdata : ram_rdata;

    assign touch     = done;
    assign touch_way = way_sel;

    // completion data
    always_comb begin
        if (is_write) begin
            rsp_sel.data = '0;
        end else if (hit) begin
            rsp_sel.data = hit_data;
        end else begin
            rsp_sel.data = ram_rdata;
        end
    end

    // keep the last completion between done pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_q <= '0;
        end else if (done) begin
            rsp_q <= rsp_sel;
        end
    end

    assign rsp = done ? rsp_sel : rsp_q;

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("cache_ctrl: done held longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        accept |=> (!req_ready throughout done[->1]))
        else $error("cache_ctrl: req_ready rose while a request was busy");

    // completion lands inside the hit/miss window
    assert property (@(posedge clk) disable iff (rst)
        accept |-> ##[cache_pkg::HIT_LATENCY:cache_pkg::MISS_LATENCY] done)
        else $error("cache_ctrl: done missed the latency window");

endmodule

/* design/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
    parameter int ways = cache_pkg::DEF_WAYS,
    parameter int sets = cache_pkg::DEF_SETS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  cache_pkg::cache_req_t req,
    output logic                  req_ready,
    output logic                  done,
    output cache_pkg::cache_rsp_t rsp
);

    // lookup path
    logic [$clog2(sets)-1:0]                       lookup_index;
    logic [cache_pkg::ADDR_WIDTH-$clog2(sets)-1:0] lookup_tag;
    logic                                          hit;
    logic [$clog2(ways)-1:0]                       hit_way;
    logic [cache_pkg::DATA_WIDTH-1:0]              hit_data;
    logic [ways-1:0]                               valid_mask;

    // line update
    logic                                          line_we;
    logic [$clog2(ways)-1:0]                       line_way;
    logic [cache_pkg::DATA_WIDTH-1:0]              line_data;

    // replacement
    logic [$clog2(ways)-1:0]                       victim_way;
    logic                                          touch;
    logic [$clog2(ways)-1:0]                       touch_way;

    // backing RAM
    logic                                          ram_en;
    logic                                          ram_we;
    logic [cache_pkg::ADDR_WIDTH-1:0]              ram_addr;
    logic [cache_pkg::DATA_WIDTH-1:0]              ram_wdata;
    logic [cache_pkg::DATA_WIDTH-1:0]              ram_rdata;

    cache_ctrl #(.ways(ways), .sets(sets)) u_ctrl (.*);

    cache_way_store #(.ways(ways), .sets(sets)) u_way_store (.*);

    cache_lru #(.ways(ways), .sets(sets)) u_lru (.*);

    ram_store u_ram (
        .clk   (clk),
        .rst   (rst),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // reset drops just after an edge so it never races the clock
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int ways = cache_pkg::DEF_WAYS;
    localparam int sets = cache_pkg::DEF_SETS;
    localparam int num_rand = 200;
    // fill + read, then write, write, read per address, then random traffic
    localparam int num_req = 5 * cache_pkg::RAM_DEPTH + num_rand;
    localparam int timeout_cycles = num_req * 5 + 100;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    cache_pkg::cache_req_t req;
    logic                  req_ready;
    logic                  done;
    cache_pkg::cache_rsp_t rsp;

    integer seed = 61;
    int     cyc = 0;

    // reference model state
    logic [cache_pkg::DATA_WIDTH-1:0] shadow [cache_pkg::RAM_DEPTH];
    int rec_tag [sets][ways];
    int rec_cnt [sets];

    // outstanding request as seen at acceptance
    cache_pkg::cache_req_t pend_req;
    logic                  busy = 1'b0;
    int                    acc_cyc = 0;
    int                    exp_lat = 0;
    int                    done_count = 0;
    cache_pkg::cache_rsp_t rsp_prev = '0;

    tb_clk_gen #(.period_ns(8.0), .reset_cycles(5)) u_clk_gen (.clk(clk), .rst(rst));

    cache_top #(.ways(ways), .sets(sets)) u_dut (.*);

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input int got, input int exp);
        stop_with($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // true when the address sits among the valid lines of its set
    function automatic logic lookup_hit(input int addr);
        int set;
        logic found;
        set = addr % sets;
        found = 1'b0;
        for (int i = 0; i < rec_cnt[set]; i++) begin
            if (rec_tag[set][i] == addr / sets) found = 1'b1;
        end
        return found;
    endfunction

    // most recent first, the oldest entry falls off a full set
    task automatic lru_touch(input int addr);
        int set;
        int pos;
        set = addr % sets;
        pos = -1;
        for (int i = 0; i < rec_cnt[set]; i++) begin
            if (rec_tag[set][i] == addr / sets) pos = i;
        end
        if (pos < 0) begin
            if (rec_cnt[set] < ways) begin
                pos = rec_cnt[set];
                rec_cnt[set]++;
            end else begin
                pos = ways - 1;
            end
        end
        for (int i = pos; i > 0; i--) begin
            rec_tag[set][i] = rec_tag[set][i-1];
        end
        rec_tag[set][0] = addr / sets;
    endtask

    // present one request and hold it until the accepting edge
    task automatic send_request(input cache_pkg::cache_op_e op, input int addr, input int wdata);
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = cache_pkg::ADDR_WIDTH'(addr);
        req.wdata = cache_pkg::DATA_WIDTH'(wdata);
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            stop_with($sformatf("timeout, the run did not finish in %0d cycles", timeout_cycles));
        end
    end

    // checks against the model, values seen just before each edge
    always @(posedge clk) begin
        logic [cache_pkg::DATA_WIDTH-1:0] exp_data;
        if (!rst) begin
            if (busy) begin
                assert (!req_ready) else value_mismatch("req_ready", req_ready, 0);
            end
            if (!done) begin
                assert (rsp == rsp_prev) else value_mismatch("rsp", rsp, rsp_prev);
            end
            if (done) begin
                assert (busy) else stop_with("done pulsed with no request outstanding");
                assert (cyc - acc_cyc == exp_lat)
                    else value_mismatch("done latency", cyc - acc_cyc, exp_lat);
                if (pend_req.op == cache_pkg::OP_WRITE) begin
                    exp_data = '0;
                end else begin
                    exp_data = shadow[pend_req.addr];
                end
                assert (rsp.data == exp_data) else value_mismatch("rsp.data", rsp.data, exp_data);
                if (pend_req.op == cache_pkg::OP_WRITE) shadow[pend_req.addr] = pend_req.wdata;
                lru_touch(pend_req.addr);
                busy = 1'b0;
                done_count++;
            end else if (busy && (cyc - acc_cyc >= exp_lat)) begin
                stop_with($sformatf("done missing %0d cycles after acceptance", cyc - acc_cyc));
            end
            // acceptance, hit or miss predicted before the line changes
            if (req_valid && req_ready) begin
                if (lookup_hit(req.addr)) begin
                    exp_lat = cache_pkg::HIT_LATENCY;
                end else begin
                    exp_lat = cache_pkg::MISS_LATENCY;
                end
                pend_req = req;
                acc_cyc  = cyc;
                busy     = 1'b1;
            end
        end
        rsp_prev = rsp;
    end

    // one cycle pulse, and never ready while completing
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else stop_with("done stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) done |-> !req_ready)
        else stop_with("req_ready was high in the cycle of done");

    initial begin
        int rnd;
        int addr;
        cache_pkg::cache_op_e op;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < cache_pkg::RAM_DEPTH; i++) shadow[i] = '0;
        for (int s = 0; s < sets; s++) rec_cnt[s] = 0;

        @(negedge rst);
        @(posedge clk);
        #1;
        // idle state straight after reset
        assert (req_ready == 1'b1) else value_mismatch("req_ready", req_ready, 1);
        assert (done == 1'b0) else value_mismatch("done", done, 0);
        assert (rsp.data == '0) else value_mismatch("rsp.data", rsp.data, 0);

        // fill every address, then read it all back
        for (int a = 0; a < cache_pkg::RAM_DEPTH; a++) begin
            send_request(cache_pkg::OP_WRITE, a, a ^ 8'h5a);
        end
        for (int a = 0; a < cache_pkg::RAM_DEPTH; a++) begin
            send_request(cache_pkg::OP_READ, a, 0);
        end

        // overwrite on a fresh line, then on the hit, then read
        for (int a = 0; a < cache_pkg::RAM_DEPTH; a++) begin
            send_request(cache_pkg::OP_WRITE, a, a * 3 + 1);
            send_request(cache_pkg::OP_WRITE, a, ~a);
            send_request(cache_pkg::OP_READ, a, 0);
        end

        // random mix, half of it in a small pool so sets see reuse and eviction
        for (int i = 0; i < num_rand; i++) begin
            rnd = $random(seed);
            op = cache_pkg::cache_op_e'(rnd[0]);
            if (rnd[1]) begin
                addr = rnd[15:8] % 24;
            end else begin
                addr = rnd[23:16];
            end
            send_request(op, addr, rnd[31:24]);
        end

        while (done_count < num_req) begin
            @(posedge clk);
            #1;
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
design/cache_pkg.sv
design/ram_store.sv
design/cache_way_store.sv
design/cache_lru.sv
design/cache_ctrl.sv
design/cache_top.sv
verification/tb_clk_gen.sv
verification/cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - files:
      - design/cache_pkg.sv
      - design/ram_store.sv
      - design/cache_way_store.sv
      - design/cache_lru.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/cache_tb.sv
